// ==== compile.f ====
src/fpu_pkg.sv
src/fpu_operand_if.sv
src/fpu_stage_if.sv
src/fpu_unpack.sv
src/fpu_arith.sv
src/fpu_normalize.sv
src/fpu_pack.sv
src/fpu_top.sv
dv/fpu_sva.sv
dv/fpu_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds the FPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f compile.f --top-module fpu_tb -Mdir obj_dir -o fpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fpu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// ==== dv/fpu_tb.sv ====
module fpu_tb import fpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PIPE_DEPTH  = 3;
    localparam int Q_DEPTH     = PIPE_DEPTH + 2;   // plus drive edge and read edge
    localparam int N_RANDOM    = 3000;
    localparam int CYCLE_LIMIT = 16 + 40 + N_RANDOM + PIPE_DEPTH + 100;

    logic              clk = 1'b0;
    logic              rst;
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    logic [1:0]        sel;
    logic [WORD_W-1:0] y;
    logic              err;
    logic              overflow;

    logic [31:0] lcg_state = 32'hc552_46b6;
    int          cycles    = 0;
    logic [33:0] exp_q[$];    // {y, err, overflow}
    string       desc_q[$];

    fpu_top DUT (.clk(clk), .rst(rst), .a(a), .b(b), .sel(sel),
                 .y(y), .err(err), .overflow(overflow));

    bind fpu_pack fpu_sva u_sva (.clk(clk), .rst(rst), .y(y), .err(err), .overflow(overflow));

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: no finish after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // integer model of the truncating datapath
    function automatic logic [33:0] fpu_model(input logic [31:0] a_in, input logic [31:0] b_in,
                                              input logic [1:0] op_in);
        fp_word_u    wa;
        fp_word_u    wb;
        fp_word_u    r;
        logic        sa, sb, sign, is_mul, ovf;
        logic        a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
        logic [23:0] ma, mb, big_m, small_m;
        logic [24:0] sum;
        logic [47:0] mant;
        int          ea, eb, e, diff, p;
        wa.bits = a_in;
        wb.bits = b_in;
        r.bits  = '0;
        ovf     = 1'b0;
        p       = 0;
        is_mul  = (op_in == OP_MUL);
        sa      = wa.f.sign;
        sb      = wb.f.sign ^ (op_in == OP_SUB);
        ea      = wa.f.exp;
        eb      = wb.f.exp;
        a_zero  = (ea == 0);
        b_zero  = (eb == 0);
        a_inf   = (ea == 255) && (wa.f.frac == '0);
        b_inf   = (eb == 255) && (wb.f.frac == '0);
        a_nan   = (ea == 255) && (wa.f.frac != '0);
        b_nan   = (eb == 255) && (wb.f.frac != '0);
        ma      = a_zero ? 24'd0 : {1'b1, wa.f.frac};
        mb      = b_zero ? 24'd0 : {1'b1, wb.f.frac};
        if ((op_in == OP_DIV) || a_nan || b_nan || (!is_mul && a_inf && b_inf) ||
            (is_mul && ((a_inf && b_zero) || (a_zero && b_inf))))
            return {QNAN_WORD, 1'b1, 1'b0};
        if (a_inf || b_inf)
        begin
            r.f.sign = is_mul ? (sa ^ sb) : (a_inf ? sa : sb);
            r.f.exp  = 8'hff;
            return {r.bits, 1'b0, 1'b1};
        end
        if (is_mul)
        begin
            mant = 48'(ma) * 48'(mb);
            e    = ea + eb - 127;
            sign = sa ^ sb;
        end
        else
        begin
            if ((ea > eb) || ((ea == eb) && (ma >= mb)))
            begin
                big_m   = ma;
                small_m = mb;
                e       = ea;
                sign    = sa;
                diff    = ea - eb;
            end
            else
            begin
                big_m   = mb;
                small_m = ma;
                e       = eb;
                sign    = sb;
                diff    = eb - ea;
            end
            small_m = (diff > 24) ? 24'd0 : (small_m >> diff);
            sum     = (sa == sb) ? ({1'b0, big_m} + small_m) : ({1'b0, big_m} - small_m);
            mant    = {sum, 23'd0};
        end
        if (mant == '0)
        begin
            r.f.sign = is_mul ? sign : (a_zero && b_zero && sa);
            return {r.bits, 2'b00};
        end
        for (int i = 0; i < 48; i++)
            if (mant[i])
                p = i;   // leading one position
        e        = e + p - 46;
        mant     = mant << (47 - p);
        r.f.sign = sign;
        if (e >= 255)
        begin
            r.f.exp = 8'hff;
            ovf     = 1'b1;
        end
        else if (e <= 0)
            ovf = 1'b1;
        else
        begin
            r.f.exp  = e[7:0];
            r.f.frac = mant[46:24];
        end
        return {r.bits, 1'b0, ovf};
    endfunction

    task automatic check_value(input logic [33:0] actual, input logic [33:0] expected,
                               input string msg);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // check the oldest result and issue the next op on one edge
    task automatic step(input logic [31:0] a_in, input logic [31:0] b_in,
                        input logic [1:0] op_in, input bit issue);
        @(posedge clk);
        if (exp_q.size() == Q_DEPTH || (!issue && exp_q.size() > 0))
            check_value({y, err, overflow}, exp_q.pop_front(), desc_q.pop_front());
        if (issue)
        begin
            a   <= a_in;
            b   <= b_in;
            sel <= op_in;
            exp_q.push_back(fpu_model(a_in, b_in, op_in));
            desc_q.push_back($sformatf("a=%h b=%h sel=%0d", a_in, b_in, op_in));
        end
    endtask

    function automatic int clamp_exp(input int e);
        return (e < 1) ? 1 : ((e > 254) ? 254 : e);
    endfunction

    // mul exponents clustered low, mid and high
    function automatic int mul_exp();
        logic [31:0] r;
        r = lcg_next();
        case (r[31:30])
            2'd0:    return 1 + int'(r[15:8] % 40);
            2'd1:    return 215 + int'(r[15:8] % 40);
            default: return 100 + int'(r[15:8] % 55);
        endcase
    endfunction

    function automatic logic [31:0] special_word();
        logic [31:0] r;
        r = lcg_next();
        case (r[2:0])
            3'd0:    return {r[31], 31'h0};
            3'd1:    return {r[31], 8'hff, 23'h0};
            3'd2:    return {r[31], 8'hff, r[22:1], 1'b1};
            3'd3:    return {r[31], 8'h00, r[22:0]};   // denormal
            default: return {r[31], 8'h7f, 23'h0};
        endcase
    endfunction

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] fa, fb;
        logic [1:0]  op;
        int          ea, eb;
        r  = lcg_next();
        op = r[31:30];
        fa = lcg_next();
        fb = lcg_next();
        if (op == OP_MUL)
        begin
            ea = mul_exp();
            eb = mul_exp();
        end
        else
        begin
            ea = 1 + int'(r[7:0] % 254);
            case (r[9:8])
                2'd0: eb = 1 + int'(r[23:16] % 254);
                2'd1: eb = clamp_exp(ea + int'(r[18:16]) - 3);
                2'd2: eb = clamp_exp(ea - 20 - int'(r[19:16]));   // past the 24-bit window
                default:
                begin
                    eb = ea;
                    fb = fa ^ {29'h0, r[18:16]};   // near cancellation
                end
            endcase
        end
        fa = {fa[31], 8'(ea), fa[22:0]};
        fb = {fb[31], 8'(eb), fb[22:0]};
        if (r[13:10] == 4'd0)
            fa = special_word();
        if (r[29:26] == 4'd0)
            fb = special_word();
        step(fa, fb, op, 1'b1);
    endtask

    initial
    begin
        rst <= 1'b1;
        a   <= '0;
        b   <= '0;
        sel <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value({y, err, overflow}, 34'd0, "outputs after reset");
        step(32'h7fc0_0000, 32'h3f80_0000, OP_ADD, 1'b1);
        step(32'h7f80_0000, 32'hff80_0000, OP_ADD, 1'b1);
        step(32'h7f80_0000, 32'h7f80_0000, OP_SUB, 1'b1);
        step(32'h7f80_0000, 32'h3f80_0000, OP_ADD, 1'b1);
        step(32'h3f80_0000, 32'h7f80_0000, OP_SUB, 1'b1);
        step(32'h7f80_0000, 32'h0000_0000, OP_MUL, 1'b1);
        step(32'h0000_0000, 32'hff80_0000, OP_MUL, 1'b1);
        step(32'hff80_0000, 32'h4000_0000, OP_MUL, 1'b1);
        step(32'h3f80_0000, 32'h7fa0_0001, OP_MUL, 1'b1);
        step(32'h0000_0000, 32'h0000_0000, OP_ADD, 1'b1);
        step(32'h8000_0000, 32'h8000_0000, OP_ADD, 1'b1);
        step(32'h8000_0000, 32'h0000_0000, OP_ADD, 1'b1);
        step(32'h0000_0000, 32'h0000_0000, OP_SUB, 1'b1);
        step(32'h3fc0_0000, 32'h3fc0_0000, OP_SUB, 1'b1);
        step(32'hc000_0000, 32'h4000_0000, OP_ADD, 1'b1);
        step(32'hc040_0000, 32'h0000_0000, OP_MUL, 1'b1);
        step(32'h0000_0001, 32'h3f80_0000, OP_ADD, 1'b1);
        step(32'h3f80_0000, 32'h3380_0000, OP_ADD, 1'b1);
        step(32'h3f80_0000, 32'h3280_0000, OP_SUB, 1'b1);
        step(32'h4040_0000, 32'h3f00_0000, OP_MUL, 1'b1);
        step(32'h7f7f_ffff, 32'h7f7f_ffff, OP_MUL, 1'b1);
        step(32'h0080_0000, 32'h0080_0000, OP_MUL, 1'b1);
        step(32'h7f7f_ffff, 32'h7f7f_ffff, OP_ADD, 1'b1);
        step(32'h3f80_0001, 32'hbf80_0000, OP_ADD, 1'b1);
        for (int i = 0; i < 8; i++)
            step(lcg_next(), lcg_next(), OP_DIV, 1'b1);
        for (int i = 0; i < N_RANDOM; i++)
            random_op();
        while (exp_q.size() > 0)
            step('0, '0, OP_ADD, 1'b0);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== dv/fpu_sva.sv ====
module fpu_sva import fpu_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic [WORD_W-1:0] y,
    input logic              err,
    input logic              overflow
);

    timeunit 1ns;
    timeprecision 100ps;

    // err only ever comes with the canonical NaN
    err_gives_qnan: assert property (@(posedge clk) disable iff (rst)
        err |-> (y == QNAN_WORD))
        else $error("err set without canonical NaN on y");

    // overflow means infinity or a flushed zero
    ovf_gives_inf_or_zero: assert property (@(posedge clk) disable iff (rst)
        overflow |-> (((y[30:23] == 8'h00) || (y[30:23] == 8'hff)) && (y[22:0] == '0)))
        else $error("overflow set with a finite nonzero result");

    outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({y, err, overflow}))
        else $error("unknown value on pack outputs");

endmodule

// ==== src/fpu_top.sv ====
module fpu_top import fpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [WORD_W-1:0] a,
    input  logic [WORD_W-1:0] b,
    input  logic [1:0]        sel,
    output logic [WORD_W-1:0] y,
    output logic              err,
    output logic              overflow
);

    fpu_operand_if opnd ();
    fpu_stage_if   arith_q ();   // after align/add or multiply
    fpu_stage_if   norm_q ();    // after leading-one shift

    // stage 0
    fpu_unpack u_unpack (
        .clk  (clk),
        .rst  (rst),
        .a    (a),
        .b    (b),
        .sel  (sel),
        .opnd (opnd.producer)
    );

    // stage 1
    fpu_arith u_arith (
        .clk  (clk),
        .rst  (rst),
        .opnd (opnd.consumer),
        .res  (arith_q.producer)
    );

    // stage 2
    fpu_normalize u_normalize (
        .clk   (clk),
        .rst   (rst),
        .in_q  (arith_q.consumer),
        .out_q (norm_q.producer)
    );

    // stage 3, result three edges after sampling
    fpu_pack u_pack (
        .clk      (clk),
        .rst      (rst),
        .in_q     (norm_q.consumer),
        .y        (y),
        .err      (err),
        .overflow (overflow)
    );

endmodule

// ==== src/fpu_pack.sv ====
module fpu_pack import fpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    fpu_stage_if.consumer     in_q,
    output logic [WORD_W-1:0] y,
    output logic              err,
    output logic              overflow
);

    logic     a_zero, b_zero, a_inf, b_inf, any_nan;
    logic     is_mul;
    logic     nan_res;
    fp_word_u y_w;
    logic     err_d;
    logic     ovf_d;

    assign a_zero  = (in_q.a_cls == CLS_ZERO);
    assign b_zero  = (in_q.b_cls == CLS_ZERO);
    assign a_inf   = (in_q.a_cls == CLS_INF);
    assign b_inf   = (in_q.b_cls == CLS_INF);
    assign any_nan = (in_q.a_cls == CLS_NAN) || (in_q.b_cls == CLS_NAN);
    assign is_mul  = (in_q.op == OP_MUL);

    // invalid operations
    assign nan_res = (in_q.op == OP_DIV) || any_nan ||
                     (!is_mul && a_inf && b_inf) ||
                     (is_mul && ((a_inf && b_zero) || (a_zero && b_inf)));

    always_comb
    begin
        y_w.bits   = '0;
        err_d      = 1'b0;
        ovf_d      = 1'b0;
        y_w.f.sign = in_q.sign;
        if (nan_res)
        begin
            y_w.bits = QNAN_WORD;
            err_d    = 1'b1;
        end
        else if (a_inf || b_inf)
        begin
            y_w.f.exp = EXP_W'(EXP_MAX);   // sign already set by arith
            ovf_d     = 1'b1;
        end
        else if (in_q.mant == '0)
        begin
            // exact zero, +0 for add unless both inputs were zero
            y_w.f.sign = is_mul ? in_q.sign : (a_zero && b_zero && in_q.sign);
        end
        else if (in_q.exp >= EXP_MAX)
        begin
            y_w.f.exp = EXP_W'(EXP_MAX);
            ovf_d     = 1'b1;
        end
        else if (in_q.exp <= 0)
        begin
            ovf_d = 1'b1;   // flush to signed zero
        end
        else
        begin
            y_w.f.exp  = in_q.exp[EXP_W-1:0];
            y_w.f.frac = in_q.mant[WIDE_W-2 -: FRAC_W];   // truncate below bit 24
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            y        <= '0;
            err      <= 1'b0;
            overflow <= 1'b0;
        end
        else
        begin
            y        <= y_w.bits;
            err      <= err_d;
            overflow <= ovf_d;
        end
    end

endmodule

// ==== src/fpu_normalize.sv ====
module fpu_normalize import fpu_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    fpu_stage_if.consumer in_q,
    fpu_stage_if.producer out_q
);

    logic [5:0]        lz;
    logic [WIDE_W-1:0] mant_sh;

    // bisecting leading zero count, low end padded with ones
    function automatic logic [5:0] lzc(input logic [WIDE_W-1:0] v);
        logic [63:0] x;
        logic [5:0]  n;
        x = {v, {(64-WIDE_W){1'b1}}};
        n = '0;
        if (x[63:32] == '0)
        begin
            n[5] = 1'b1;
            x    = x << 32;
        end
        if (x[63:48] == '0)
        begin
            n[4] = 1'b1;
            x    = x << 16;
        end
        if (x[63:56] == '0)
        begin
            n[3] = 1'b1;
            x    = x << 8;
        end
        if (x[63:60] == '0)
        begin
            n[2] = 1'b1;
            x    = x << 4;
        end
        if (x[63:62] == '0)
        begin
            n[1] = 1'b1;
            x    = x << 2;
        end
        n[0] = ~x[63];
        return n;
    endfunction

    assign lz      = lzc(in_q.mant);
    assign mant_sh = in_q.mant << lz;   // leading one to bit 47

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_q.op    <= '0;
            out_q.sign  <= 1'b0;
            out_q.exp   <= '0;
            out_q.mant  <= '0;
            out_q.a_cls <= '0;
            out_q.b_cls <= '0;
        end
        else
        begin
            out_q.op    <= in_q.op;
            out_q.sign  <= in_q.sign;
            out_q.a_cls <= in_q.a_cls;
            out_q.b_cls <= in_q.b_cls;
            if (in_q.mant == '0)
            begin
                out_q.exp  <= in_q.exp;   // zero passes untouched
                out_q.mant <= '0;
            end
            else
            begin
                out_q.exp  <= in_q.exp + EXP_WIDE_W'(1) - EXP_WIDE_W'(lz);
                out_q.mant <= mant_sh;
            end
        end
    end

endmodule

// ==== src/fpu_arith.sv ====
module fpu_arith import fpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    fpu_operand_if.consumer opnd,
    fpu_stage_if.producer   res
);

    logic                          a_big;
    logic                          big_sign;
    logic [EXP_W-1:0]              big_exp;
    logic [EXP_W-1:0]              small_exp;
    logic [EXP_W-1:0]              exp_diff;
    logic [MANT_W-1:0]             big_mant;
    logic [MANT_W-1:0]             small_mant;
    logic [MANT_W-1:0]             small_algn;
    logic [MANT_W:0]               sum;
    logic [WIDE_W-1:0]             prod;
    logic signed [EXP_WIDE_W-1:0]  mul_exp;

    // add path, larger magnitude operand goes first
    always_comb
    begin
        a_big = (opnd.a_exp > opnd.b_exp) ||
                ((opnd.a_exp == opnd.b_exp) && (opnd.a_mant >= opnd.b_mant));   // ties keep a

        big_sign   = a_big ? opnd.a_sign : opnd.b_sign;
        big_exp    = a_big ? opnd.a_exp  : opnd.b_exp;
        small_exp  = a_big ? opnd.b_exp  : opnd.a_exp;
        big_mant   = a_big ? opnd.a_mant : opnd.b_mant;
        small_mant = a_big ? opnd.b_mant : opnd.a_mant;

        exp_diff = big_exp - small_exp;
        if (exp_diff > EXP_W'(MANT_W))
            small_algn = '0;   // shifted out entirely
        else
            small_algn = small_mant >> exp_diff;   // truncating alignment

        if (opnd.a_sign == opnd.b_sign)
            sum = {1'b0, big_mant} + {1'b0, small_algn};
        else
            sum = {1'b0, big_mant} - {1'b0, small_algn};   // never negative
    end

    // mul path
    assign prod    = opnd.a_mant * opnd.b_mant;
    assign mul_exp = EXP_WIDE_W'(opnd.a_exp) + EXP_WIDE_W'(opnd.b_exp)
                     - EXP_WIDE_W'(EXP_BIAS);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            res.op    <= '0;
            res.sign  <= 1'b0;
            res.exp   <= '0;
            res.mant  <= '0;
            res.a_cls <= '0;
            res.b_cls <= '0;
        end
        else
        begin
            res.op    <= opnd.op;
            res.a_cls <= opnd.a_cls;
            res.b_cls <= opnd.b_cls;
            if (opnd.op == OP_MUL)
            begin
                res.sign <= opnd.a_sign ^ opnd.b_sign;
                res.exp  <= mul_exp;
                res.mant <= prod;
            end
            else
            begin
                // div also lands here, pack overrides it
                res.sign <= big_sign;
                res.exp  <= EXP_WIDE_W'(big_exp);
                res.mant <= {sum, {(WIDE_W-MANT_W-1){1'b0}}};   // sum at bits 47..23
            end
        end
    end

endmodule

// ==== src/fpu_unpack.sv ====
module fpu_unpack import fpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [WORD_W-1:0] a,
    input  logic [WORD_W-1:0] b,
    input  logic [1:0]        sel,
    fpu_operand_if.producer   opnd
);

    fp_word_u a_w;
    fp_word_u b_w;

    assign a_w.bits = a;
    assign b_w.bits = b;

    function automatic logic [CLS_W-1:0] classify(input fp_word_u w);
        if (w.f.exp == '0)
            return CLS_ZERO;   // denormals flushed
        else if (w.f.exp == EXP_W'(EXP_MAX))
            return (w.f.frac == '0) ? CLS_INF : CLS_NAN;
        else
            return CLS_NORM;
    endfunction

    function automatic logic [MANT_W-1:0] mantissa(input fp_word_u w);
        return (classify(w) == CLS_ZERO) ? '0 : {1'b1, w.f.frac};
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            opnd.op     <= '0;
            opnd.a_sign <= 1'b0;
            opnd.a_exp  <= '0;
            opnd.a_mant <= '0;
            opnd.a_cls  <= '0;
            opnd.b_sign <= 1'b0;
            opnd.b_exp  <= '0;
            opnd.b_mant <= '0;
            opnd.b_cls  <= '0;
        end
        else
        begin
            opnd.op     <= (sel == OP_SUB) ? OP_ADD : sel;   // sub becomes add
            opnd.a_sign <= a_w.f.sign;
            opnd.a_exp  <= a_w.f.exp;
            opnd.a_mant <= mantissa(a_w);
            opnd.a_cls  <= classify(a_w);
            opnd.b_sign <= b_w.f.sign ^ (sel == OP_SUB);   // negate b for sub
            opnd.b_exp  <= b_w.f.exp;
            opnd.b_mant <= mantissa(b_w);
            opnd.b_cls  <= classify(b_w);
        end
    end

endmodule

// ==== src/fpu_stage_if.sv ====
interface fpu_stage_if import fpu_pkg::*; ();

    // value is mant * 2^(exp - bias - 46)
    logic [1:0]                    op;
    logic                          sign;
    logic signed [EXP_WIDE_W-1:0]  exp;
    logic [WIDE_W-1:0]             mant;
    logic [CLS_W-1:0]              a_cls;   // carried for the special cases
    logic [CLS_W-1:0]              b_cls;

    modport producer (
        output op,
        output sign,
        output exp,
        output mant,
        output a_cls,
        output b_cls
    );

    modport consumer (
        input op,
        input sign,
        input exp,
        input mant,
        input a_cls,
        input b_cls
    );

endinterface

// ==== src/fpu_operand_if.sv ====
interface fpu_operand_if import fpu_pkg::*; ();

    logic [1:0]       op;       // add, mul or div only
    logic             a_sign;
    logic [EXP_W-1:0] a_exp;
    logic [MANT_W-1:0] a_mant;  // hidden one included
    logic [CLS_W-1:0] a_cls;
    logic             b_sign;   // already flipped for sub
    logic [EXP_W-1:0] b_exp;
    logic [MANT_W-1:0] b_mant;
    logic [CLS_W-1:0] b_cls;

    modport producer (
        output op,
        output a_sign, a_exp, a_mant, a_cls,
        output b_sign, b_exp, b_mant, b_cls
    );

    modport consumer (
        input op,
        input a_sign, a_exp, a_mant, a_cls,
        input b_sign, b_exp, b_mant, b_cls
    );

endinterface

// ==== src/fpu_pkg.sv ====
package fpu_pkg;

    // word geometry
    localparam int WORD_W     = 32;
    localparam int EXP_W      = 8;
    localparam int FRAC_W     = 23;
    localparam int MANT_W     = 24;   // fraction plus hidden one
    localparam int WIDE_W     = 48;   // product width, also holds aligned sums
    localparam int EXP_WIDE_W = 10;   // signed, room for mul exponent range

    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;

    // sel codes
    localparam logic [1:0] OP_ADD = 2'd0;
    localparam logic [1:0] OP_SUB = 2'd1;
    localparam logic [1:0] OP_MUL = 2'd2;
    localparam logic [1:0] OP_DIV = 2'd3;   // no divider, always NaN

    // operand classes
    localparam int CLS_W = 2;
    localparam logic [CLS_W-1:0] CLS_ZERO = 2'd0;   // also denormals
    localparam logic [CLS_W-1:0] CLS_NORM = 2'd1;
    localparam logic [CLS_W-1:0] CLS_INF  = 2'd2;
    localparam logic [CLS_W-1:0] CLS_NAN  = 2'd3;

    localparam logic [WORD_W-1:0] QNAN_WORD = 32'h7fc0_0000;

    // one ieee-754 single, seen as raw bits or as fields
    typedef union packed {
        logic [WORD_W-1:0] bits;
        struct packed {
            logic              sign;
            logic [EXP_W-1:0]  exp;
            logic [FRAC_W-1:0] frac;
        } f;
    } fp_word_u;

endpackage
